// ==== bench/cdr_tb.sv ====
module cdr_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PW    = cdr_pkg::DEF_PHASE_WIDTH;
  localparam int FW    = cdr_pkg::DEF_FREQ_WIDTH;
  localparam int DECIM = cdr_pkg::DEF_DECIM;

  logic           clk          = 1'b0;
  logic           rst_n        = 1'b0;
  logic           sample_valid = 1'b0;
  logic           data_bit     = 1'b0;
  logic           edge_bit     = 1'b0;
  cdr_pkg::code_t code;
  logic           locked;

  // reference model state, advanced once per accepted clock edge
  logic          m_a;            // previous data bit
  logic          m_a_known;
  int            m_slot;         // decisions in current vote
  int            m_sum;          // late minus early in current vote
  logic [FW-1:0] m_f;            // frequency integrator
  logic [PW-1:0] m_p;            // phase integrator
  int            m_win;          // directional votes in lock window
  int            m_bal;          // late minus early in lock window
  logic          m_locked;
  logic          m_f_wrapped;    // F went below zero at least once
  int            m_late_votes;   // stats, survive reset
  int            m_early_votes;
  int            m_ties;

  // model outputs after the last three edges, index 0 newest
  cdr_pkg::code_t hist_code [3];
  logic           hist_lock [3];

  logic cur_bit; // last data bit sent
  int   err_cnt;

  cdr_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .data_bit     (data_bit),
    .edge_bit     (edge_bit),
    .code         (code),
    .locked       (locked)
  );

  initial begin
    forever #2 clk = ~clk; // 4 ns period
  end

  task automatic stop_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_code(input cdr_pkg::code_t expected, input cdr_pkg::code_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("error code expected 0x%h actual 0x%h", expected, actual));
    end
  endtask

  task automatic check_locked(input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_run($sformatf("error locked expected 0x%h actual 0x%h", expected, actual));
    end
  endtask

  function automatic void model_reset();
    m_a_known = 1'b0;
    m_slot    = 0;
    m_sum     = 0;
    m_f       = '0;
    m_p       = '0;
    m_win     = 0;
    m_bal     = 0;
    m_locked  = 1'b0;
    for (int i = 0; i < 3; i++) begin
      hist_code[i] = '0;
      hist_lock[i] = 1'b0;
    end
  endfunction

  // one sample through detector, decimator, filter and lock rules, no latency
  function automatic void model_step(input logic v, input logic d, input logic e);
    cdr_pkg::phase_dir_e dec;
    cdr_pkg::phase_dir_e vote;
    logic                vote_hit;
    int                  tap;
    vote_hit = 1'b0;
    vote     = cdr_pkg::dir_none;
    if (v) begin
      if (m_a_known) begin
        if (m_a == d) dec = cdr_pkg::dir_none;
        else if (e == d) dec = cdr_pkg::dir_late; // edge sample already new
        else dec = cdr_pkg::dir_early;
        if (dec == cdr_pkg::dir_late) m_sum++;
        if (dec == cdr_pkg::dir_early) m_sum--;
        m_slot++;
        if (m_slot == DECIM) begin
          vote_hit = 1'b1;
          if (m_sum > 0) vote = cdr_pkg::dir_late;
          else if (m_sum < 0) vote = cdr_pkg::dir_early;
          else m_ties++; // tie, vote is none
          m_slot = 0;
          m_sum  = 0;
        end
      end
      m_a       = d;
      m_a_known = 1'b1;
    end
    if (vote_hit && vote != cdr_pkg::dir_none) begin
      tap = int'(m_f[FW-2 -: 9]); // bits FW-2 .. FW-10
      if (vote == cdr_pkg::dir_late) begin
        m_late_votes++;
        m_f = m_f + FW'(cdr_pkg::DEF_FRUG);
        m_p = m_p + PW'(tap) + PW'(cdr_pkg::DEF_PHUG);
        m_bal++;
      end else begin
        m_early_votes++;
        if (m_f < FW'(cdr_pkg::DEF_FRUG)) m_f_wrapped = 1'b1;
        m_f = m_f - FW'(cdr_pkg::DEF_FRUG);
        m_p = m_p - PW'(511 - tap) - PW'(cdr_pkg::DEF_PHUG); // 511 - S is ~S
        m_bal--;
      end
      m_win++;
      if (m_win == cdr_pkg::DEF_LOCK_WINDOW) begin
        m_locked = ((m_bal < 0) ? -m_bal : m_bal) <= cdr_pkg::DEF_LOCK_TOL;
        m_win    = 0;
        m_bal    = 0;
      end
    end
  endfunction

  // inputs are stable at negedge, dut outputs lag the model by three edges
  always @(negedge clk) begin
    if (!rst_n) begin
      model_reset();
      check_code('0, code);
      check_locked(1'b0, locked);
    end else begin
      check_code(hist_code[2], code);
      check_locked(hist_lock[2], locked);
      model_step(sample_valid, data_bit, edge_bit);
      hist_code[2] = hist_code[1];
      hist_lock[2] = hist_lock[1];
      hist_code[1] = hist_code[0];
      hist_lock[1] = hist_lock[0];
      hist_code[0] = m_p[PW-1 -: cdr_pkg::CODE_WIDTH];
      hist_lock[0] = m_locked;
    end
  end

  task automatic send(input logic v, input logic d, input logic e);
    @(posedge clk);
    #1;
    sample_valid = v;
    data_bit     = d;
    edge_bit     = e;
  endtask

  task automatic send_late();
    send(1'b1, ~cur_bit, ~cur_bit); // edge sees the new bit
    cur_bit = ~cur_bit;
  endtask

  task automatic send_early();
    send(1'b1, ~cur_bit, cur_bit); // edge still sees the old bit
    cur_bit = ~cur_bit;
  endtask

  task automatic send_hold();
    send(1'b1, cur_bit, $urandom_range(1, 0)); // no transition
  endtask

  task automatic send_idle();
    send(1'b0, $urandom_range(1, 0), $urandom_range(1, 0));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // keep one direction going until the model has counted n more votes
  task automatic run_votes(input logic late, input int n_votes);
    int start;
    int guard;
    start = late ? m_late_votes : m_early_votes;
    guard = 0;
    while ((late ? m_late_votes : m_early_votes) < start + n_votes) begin
      if (late) send_late();
      else send_early();
      guard++;
      if (guard > n_votes * DECIM + 16) stop_run("timed out waiting for votes to be counted");
    end
  endtask

  initial begin
    int unsigned r;
    int          guard;
    err_cnt       = 0;
    cur_bit       = 1'b0;
    m_f_wrapped   = 1'b0;
    m_late_votes  = 0;
    m_early_votes = 0;
    m_ties        = 0;
    r             = $urandom(29720); // seed once
    rst_n         = 1'b0;
    sample_valid  = 1'b0;
    data_bit      = 1'b0;
    edge_bit      = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_code('0, code);
    check_locked(1'b0, locked);

    // no transitions, then nothing valid
    repeat (40) send_hold(); // first one only primes A
    repeat (40) send_idle();
    repeat (4) send_idle();
    check_code('0, code);
    if (m_late_votes + m_early_votes != 0) stop_run("directional vote seen without transitions");

    run_votes(1'b1, 80);    // late stream, F tap grows
    if (m_f[FW-2 -: 9] == 0) stop_run("frequency term did not grow during the late stream");
    run_votes(1'b0, 200);   // early stream, wraps F and P
    if (!m_f_wrapped) stop_run("frequency integrator did not wrap during the early stream");

    // random data, edge and valid
    repeat (2000) begin
      r = $urandom;
      send(r[1:0] != 2'b00, r[2], r[3]);
    end
    if (m_ties == 0) stop_run("random stream produced no tied vote");

    // balanced votes, aligned to vote blocks by a fresh reset
    apply_reset();
    send_hold(); // primes A
    guard = 0;
    while (locked !== 1'b1) begin
      repeat (DECIM) send_late();
      repeat (DECIM) send_early();
      guard++;
      if (guard > 40) stop_run("locked did not rise during balanced votes");
    end
    guard = 0;
    while (locked !== 1'b0) begin
      repeat (DECIM) send_late();
      guard++;
      if (guard > 60) stop_run("locked did not fall during a late stream");
    end
    repeat (4) send_idle();

    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== hw/alexander_pd.sv ====
module alexander_pd (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sample_valid, // front end has a new pair
  input  logic                data_bit,     // B, current data sample
  input  logic                edge_bit,     // T, sample taken between A and B
  output logic                pd_valid,
  output cdr_pkg::phase_dir_e pd_dir
);

  logic a_bit;   // previous data bit A
  logic a_known; // A holds a real sample

  cdr_pkg::phase_dir_e dir_next;

  // alexander truth table
  // A == B gives no information, otherwise the edge sample tells which side
  // of the transition the clock sits on
  always_comb begin
    if (a_bit == data_bit) begin
      dir_next = cdr_pkg::dir_none; // no transition
    end else if (edge_bit == data_bit) begin
      dir_next = cdr_pkg::dir_late; // edge already saw new bit
    end else begin
      dir_next = cdr_pkg::dir_early; // edge still saw old bit
    end
  end

  // previous bit register
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      a_bit <= data_bit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_known  <= 1'b0;
      pd_valid <= 1'b0;
      pd_dir   <= cdr_pkg::dir_none;
    end else begin
      if (sample_valid) begin
        a_known <= 1'b1; // first sample only primes A
      end
      if (sample_valid && a_known) begin
        pd_valid <= 1'b1;
        pd_dir   <= dir_next;
      end else begin
        pd_valid <= 1'b0;
        pd_dir   <= cdr_pkg::dir_none; // idle slots carry no direction
      end
    end
  end

  // downstream sums pd_dir without looking at pd_valid first
  a_idle_dir_none : assert property (
    @(posedge clk) disable iff (!rst_n)
    !pd_valid |-> pd_dir == cdr_pkg::dir_none
  ) else $error("pd_dir not none while pd_valid low");

endmodule

// ==== hw/cdr_pkg.sv ====
package cdr_pkg;

  // direction of one phase decision or vote
  // encoding follows {late, early} as seen by the loop filter
  typedef enum logic [1:0] {
    dir_none  = 2'b00, // no transition or tied vote
    dir_early = 2'b01, // sampling clock ahead of data
    dir_late  = 2'b10  // sampling clock behind data
  } phase_dir_e;

  // phase code to the interpolator
  localparam int CODE_WIDTH = 11;

  typedef logic [CODE_WIDTH-1:0] code_t;

  // integrator widths
  localparam int DEF_PHASE_WIDTH = 16;
  localparam int DEF_FREQ_WIDTH  = 16;

  // loop gains
  localparam int DEF_PHUG = 3; // proportional step per vote
  localparam int DEF_FRUG = 8; // integral step per vote

  // decisions summed into one vote
  localparam int DEF_DECIM = 4;

  // lock detection
  localparam int DEF_LOCK_WINDOW = 16; // directional votes per window
  localparam int DEF_LOCK_TOL    = 2;  // max |late - early| while locked

endpackage

// ==== hw/cdr_top.sv ====
module cdr_top #(
  parameter int PHUG        = cdr_pkg::DEF_PHUG,
  parameter int FRUG        = cdr_pkg::DEF_FRUG,
  parameter int PHASE_WIDTH = cdr_pkg::DEF_PHASE_WIDTH,
  parameter int FREQ_WIDTH  = cdr_pkg::DEF_FREQ_WIDTH,
  parameter int DECIM       = cdr_pkg::DEF_DECIM,
  parameter int LOCK_WINDOW = cdr_pkg::DEF_LOCK_WINDOW,
  parameter int LOCK_TOL    = cdr_pkg::DEF_LOCK_TOL
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sample_valid, // from the oversampling front end
  input  logic        data_bit,
  input  logic        edge_bit,
  output logic [10:0] code,         // to the phase interpolator
  output logic        locked
);

  // detector to decimator
  logic                pd_valid;
  cdr_pkg::phase_dir_e pd_dir;

  // decimator to filter and lock detector
  logic                vote_valid;
  cdr_pkg::phase_dir_e vote_dir;

  alexander_pd u_pd (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .data_bit     (data_bit),
    .edge_bit     (edge_bit),
    .pd_valid     (pd_valid),
    .pd_dir       (pd_dir)
  );

  vote_decimator #(
    .DECIM (DECIM)
  ) u_decim (
    .clk        (clk),
    .rst_n      (rst_n),
    .pd_valid   (pd_valid),
    .pd_dir     (pd_dir),
    .vote_valid (vote_valid),
    .vote_dir   (vote_dir)
  );

  // sample to code is three register stages
  digital_loop_filter #(
    .PHUG        (PHUG),
    .FRUG        (FRUG),
    .PHASE_WIDTH (PHASE_WIDTH),
    .FREQ_WIDTH  (FREQ_WIDTH)
  ) u_filter (
    .clk        (clk),
    .rst_n      (rst_n),
    .vote_valid (vote_valid),
    .vote_dir   (vote_dir),
    .code       (code)
  );

  lock_detector #(
    .LOCK_WINDOW (LOCK_WINDOW),
    .LOCK_TOL    (LOCK_TOL)
  ) u_lock (
    .clk        (clk),
    .rst_n      (rst_n),
    .vote_valid (vote_valid),
    .vote_dir   (vote_dir),
    .locked     (locked)
  );

endmodule

// ==== hw/digital_loop_filter.sv ====
module digital_loop_filter #(
  parameter int PHUG        = 3,  // proportional gain
  parameter int FRUG        = 8,  // integral gain
  parameter int PHASE_WIDTH = 16,
  parameter int FREQ_WIDTH  = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                vote_valid,
  input  cdr_pkg::phase_dir_e vote_dir,
  output cdr_pkg::code_t      code
);

  // elaboration time width check
  if (PHASE_WIDTH < cdr_pkg::CODE_WIDTH || FREQ_WIDTH < 10) begin : g_bad_width
    $error("digital_loop_filter needs PHASE_WIDTH >= CODE_WIDTH and FREQ_WIDTH >= 10");
  end

  logic [FREQ_WIDTH-1:0]  freq_int;  // F, integral path
  logic [PHASE_WIDTH-1:0] phase_int; // P, drives the code
  logic [8:0]             freq_tap;  // S, slice of F fed into P

  logic [PHASE_WIDTH-1:0] tap_up;    // S zero extended
  logic [PHASE_WIDTH-1:0] tap_dn;    // ~S zero extended

  // skip the msb of F so the tap stays inside 9 bits
  assign freq_tap  = freq_int[FREQ_WIDTH-2 -: 9];
  assign tap_up    = PHASE_WIDTH'(freq_tap);
  assign tap_dn    = {{(PHASE_WIDTH-9){1'b0}}, ~freq_tap}; // invert only the 9 tap bits

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      freq_int  <= '0;
      phase_int <= '0;
    end else if (vote_valid) begin
      case (vote_dir)
        cdr_pkg::dir_late: begin
          // clock behind, speed up
          freq_int  <= freq_int + FREQ_WIDTH'(FRUG);
          phase_int <= phase_int + tap_up + PHASE_WIDTH'(PHUG); // old F tap
        end
        cdr_pkg::dir_early: begin
          // clock ahead, slow down
          freq_int  <= freq_int - FREQ_WIDTH'(FRUG);
          phase_int <= phase_int - tap_dn - PHASE_WIDTH'(PHUG);
        end
        default: begin
          // tied vote holds both integrators
          freq_int  <= freq_int;
          phase_int <= phase_int;
        end
      endcase
    end
  end

  // both integrators wrap, the code is just the top bits of P
  assign code = phase_int[PHASE_WIDTH-1 -: cdr_pkg::CODE_WIDTH];

endmodule

// ==== hw/lock_detector.sv ====
module lock_detector #(
  parameter int LOCK_WINDOW = 16, // directional votes per window
  parameter int LOCK_TOL    = 2   // max |late - early| for lock
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                vote_valid,
  input  cdr_pkg::phase_dir_e vote_dir,
  output logic                locked
);

  localparam int CNT_W = $clog2(LOCK_WINDOW + 1);
  localparam int BAL_W = CNT_W + 1; // signed, covers +-LOCK_WINDOW

  logic        [CNT_W-1:0] vote_cnt;  // directional votes in window
  logic signed [BAL_W-1:0] balance;   // late minus early
  logic        [CNT_W-1:0] cnt_next;
  logic signed [BAL_W-1:0] bal_next;
  logic        [BAL_W-1:0] bal_mag;   // |bal_next|
  logic                    dir_vote;  // vote carries a direction
  logic                    window_end;

  assign dir_vote = vote_valid && (vote_dir != cdr_pkg::dir_none);
  assign cnt_next = vote_cnt + 1'b1;

  always_comb begin
    if (vote_dir == cdr_pkg::dir_late) begin
      bal_next = balance + BAL_W'(1);
    end else begin
      bal_next = balance - BAL_W'(1); // only early reaches here when used
    end
  end

  assign bal_mag    = bal_next[BAL_W-1] ? $unsigned(-bal_next) : $unsigned(bal_next);
  assign window_end = (cnt_next == CNT_W'(LOCK_WINDOW));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vote_cnt <= '0;
      balance  <= '0;
      locked   <= 1'b0;
    end else if (dir_vote) begin
      if (window_end) begin
        // balanced window means the loop sits on the data eye
        locked   <= (bal_mag <= BAL_W'(LOCK_TOL));
        vote_cnt <= '0;
        balance  <= '0;
      end else begin
        vote_cnt <= cnt_next;
        balance  <= bal_next;
      end
    end
  end

  // lock status goes off chip and must always be defined
  a_locked_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(locked)
  ) else $error("locked is unknown after reset");

endmodule

// ==== hw/vote_decimator.sv ====
module vote_decimator #(
  parameter int DECIM = 4 // decision slots per vote
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pd_valid,
  input  cdr_pkg::phase_dir_e pd_dir,
  output logic                vote_valid,
  output cdr_pkg::phase_dir_e vote_dir
);

  localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;
  localparam int SUM_W = $clog2(DECIM + 1) + 1; // holds -DECIM..+DECIM

  logic        [CNT_W-1:0] slot;     // slots seen in this vote
  logic signed [SUM_W-1:0] sum;      // late minus early so far
  logic signed [SUM_W-1:0] delta;    // contribution of this slot
  logic signed [SUM_W-1:0] sum_next;
  logic                    last_slot;

  always_comb begin
    case (pd_dir)
      cdr_pkg::dir_late:  delta = SUM_W'(1);
      cdr_pkg::dir_early: delta = -SUM_W'(1);
      default:            delta = '0; // none adds nothing
    endcase
  end

  assign sum_next  = sum + delta;
  assign last_slot = (slot == CNT_W'(DECIM - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot       <= '0;
      sum        <= '0;
      vote_valid <= 1'b0;
      vote_dir   <= cdr_pkg::dir_none;
    end else begin
      vote_valid <= 1'b0;
      vote_dir   <= cdr_pkg::dir_none;
      if (pd_valid) begin
        if (last_slot) begin
          // majority of the block decides, ties give none
          vote_valid <= 1'b1;
          if (sum_next > 0) begin
            vote_dir <= cdr_pkg::dir_late;
          end else if (sum_next < 0) begin
            vote_dir <= cdr_pkg::dir_early;
          end else begin
            vote_dir <= cdr_pkg::dir_none;
          end
          slot <= '0; // start next block
          sum  <= '0;
        end else begin
          slot <= slot + 1'b1;
          sum  <= sum_next;
        end
      end
    end
  end

  // a vote needs DECIM detector slots, so votes come spaced apart
  a_vote_spacing : assert property (
    @(posedge clk) disable iff (!rst_n)
    (DECIM > 1) && vote_valid |=> !vote_valid
  ) else $error("vote_valid high on back to back cycles");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the cdr testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cdr_tb -f sim.f -o cdr_sim || exit 1
out=$(./obj_dir/cdr_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && echo "sim passed" || {
  echo "sim failed"
  exit 1
}

// ==== sim.f ====
hw/cdr_pkg.sv
hw/alexander_pd.sv
hw/vote_decimator.sv
hw/digital_loop_filter.sv
hw/lock_detector.sv
hw/cdr_top.sv
bench/cdr_tb.sv
